//--- tb.f
+incdir+.
mac_mem_pkg.sv
mac_ctrl_pkg.sv
mac_tcdm_if.sv
mac_stream_ctrl.sv
mac_tcdm_mux.sv
mac_load_channel.sv
mac_store_channel.sv
mac_streamer_top.sv
tb_mac_mem_model.sv
tb_mac_streamer.sv

//--- Bender.yml
package:
  name: mac_streamer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mac_mem_pkg.sv
      - mac_ctrl_pkg.sv
      - mac_tcdm_if.sv
      - mac_stream_ctrl.sv
      - mac_tcdm_mux.sv
      - mac_load_channel.sv
      - mac_store_channel.sv
      - mac_streamer_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mac_mem_model.sv
      - tb_mac_streamer.sv

//--- tb_mac_streamer.sv
/*
 * testbench of the MAC memory streamer
 * runs MAC and simple-multiply jobs against a random-grant memory model
 * and an engine model that returns credits at random times
 */

`default_nettype none

`include "mac_streamer_params.svh"

module tb_mac_streamer
  import mac_mem_pkg::*;
  import mac_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT   = 20000;
  localparam int CREDITS   = `MAC_CONSUMER_CREDITS;
  localparam int MEM_WORDS = 256;

  logic  clk, rst_n, start, simple_mul;
  cnt_t  pairs, n_out;
  addr_t a_base, b_base, c_base, d_base;
  logic  busy, done;
  logic  mem_req, mem_wen, mem_gnt, mem_r_valid;
  addr_t mem_add;
  word_t mem_data, mem_r_data;
  logic  a_valid, b_valid, c_valid, d_valid;
  word_t a_data, b_data, c_data, d_data;
  logic  a_credit, b_credit, c_credit, d_credit;

  // engine model state
  word_t got_a [$], got_b [$], got_c [$];
  word_t work_a [$], work_b [$], work_c [$];
  word_t d_out [$];
  int    owed [3] = '{default: 0};
  int    sent [3] = '{default: 0};
  int    ret [3]  = '{default: 0};
  int    d_cred = 0, d_cred_total = 0, d_writes = 0;
  int    job_pairs = 1, job_n_out = 1, credit_pct = 50;
  bit    job_simple = 1'b0;
  int    d_grants = 0, done_cnt = 0;
  bit    done_due = 1'b0;

  // expected requests, beats and results
  addr_t exp_add [$];
  logic  exp_rd [$];
  word_t exp_a [$], exp_b [$], exp_c [$], exp_d [$];

  mac_streamer_top i_dut (
    .clk_i (clk), .rst_ni (rst_n), .start_i (start), .simple_mul_i (simple_mul),
    .pairs_i (pairs), .n_out_i (n_out),
    .a_base_i (a_base), .b_base_i (b_base), .c_base_i (c_base), .d_base_i (d_base),
    .busy_o (busy), .done_o (done),
    .mem_req_o (mem_req), .mem_add_o (mem_add), .mem_wen_o (mem_wen),
    .mem_data_o (mem_data), .mem_gnt_i (mem_gnt), .mem_r_valid_i (mem_r_valid),
    .mem_r_data_i (mem_r_data),
    .a_valid_o (a_valid), .a_data_o (a_data), .a_credit_i (a_credit),
    .b_valid_o (b_valid), .b_data_o (b_data), .b_credit_i (b_credit),
    .c_valid_o (c_valid), .c_data_o (c_data), .c_credit_i (c_credit),
    .d_valid_i (d_valid), .d_data_i (d_data), .d_credit_o (d_credit)
  );

  tb_mac_mem_model #(.WORDS(MEM_WORDS), .GNT_PCT(60)) i_mem (
    .clk_i (clk), .rst_ni (rst_n), .req_i (mem_req), .add_i (mem_add),
    .wen_i (mem_wen), .data_i (mem_data), .gnt_o (mem_gnt),
    .r_valid_o (mem_r_valid), .r_data_o (mem_r_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // error reporting
  // --------------------

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // --------------------
  // reference
  // --------------------

  function automatic word_t mem_word(input addr_t add);
    return i_mem.mem[int'((add >> 2) % MEM_WORDS)];
  endfunction

  function automatic void expect_request(input addr_t add, input logic rd);
    exp_add.push_back(add);
    exp_rd.push_back(rd);
  endfunction

  // (a, b) x pairs, then c, then d per result; simple mode is a, b, d
  function automatic void build_reference(input bit simple, input int np, input int no);
    int    j;
    int    p;
    int    k;
    word_t acc;
    word_t wa;
    word_t wb;
    word_t wc;
    exp_add.delete();
    exp_rd.delete();
    exp_a.delete();
    exp_b.delete();
    exp_c.delete();
    exp_d.delete();
    k = 0;
    for (j = 0; j < no; j++) begin
      acc = '0;
      for (p = 0; p < (simple ? 1 : np); p++) begin
        wa = mem_word(a_base + addr_t'(`MAC_WORD_BYTES * k));
        wb = mem_word(b_base + addr_t'(`MAC_WORD_BYTES * k));
        expect_request(a_base + addr_t'(`MAC_WORD_BYTES * k), 1'b1);
        expect_request(b_base + addr_t'(`MAC_WORD_BYTES * k), 1'b1);
        exp_a.push_back(wa);
        exp_b.push_back(wb);
        acc += wa * wb;
        k++;
      end
      if (!simple) begin
        wc = mem_word(c_base + addr_t'(`MAC_WORD_BYTES * j));
        expect_request(c_base + addr_t'(`MAC_WORD_BYTES * j), 1'b1);
        exp_c.push_back(wc);
        acc += wc;
      end
      expect_request(d_base + addr_t'(`MAC_WORD_BYTES * j), 1'b0);
      exp_d.push_back(acc);
    end
  endfunction

  // --------------------
  // engine model
  // --------------------

  // one beat in, credit check against what was handed back so far
  task automatic take_beat(input int s, input logic v, input word_t d, input logic cr);
    if (v) begin
      sent[s]++;
      assert (sent[s] <= CREDITS + ret[s])
        else stop_on_error($sformatf("stream %0d sent a beat without a credit", s));
      owed[s]++;
      case (s)
        0: begin
          got_a.push_back(d);
          work_a.push_back(d);
        end
        1: begin
          got_b.push_back(d);
          work_b.push_back(d);
        end
        default: begin
          got_c.push_back(d);
          work_c.push_back(d);
        end
      endcase
    end
    if (cr) begin
      ret[s]++;
    end
  endtask

  task automatic compute_result();
    word_t acc;
    if (work_a.size() >= job_pairs && work_b.size() >= job_pairs &&
        (job_simple || work_c.size() > 0)) begin
      acc = '0;
      repeat (job_pairs) acc += work_a.pop_front() * work_b.pop_front();
      if (!job_simple) begin
        acc += work_c.pop_front();
      end
      d_out.push_back(acc);
    end
  endtask

  function automatic logic give_credit(input int s);
    if (owed[s] > 0 && $urandom_range(99) < credit_pct) begin
      owed[s]--;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // engine outputs, driven just after the edge
  always @(posedge clk) begin
    #1;
    a_credit = give_credit(0);
    b_credit = give_credit(1);
    c_credit = give_credit(2);
    d_valid  = 1'b0;
    if (d_cred > 0 && d_out.size() > 0 && $urandom_range(99) < 70) begin
      d_valid = 1'b1;
      d_data  = d_out.pop_front();
      d_cred--;
    end
  end

  // --------------------
  // monitor
  // --------------------

  always @(negedge clk) begin
    if (rst_n) begin
      take_beat(0, a_valid, a_data, a_credit);
      take_beat(1, b_valid, b_data, b_credit);
      take_beat(2, c_valid, c_data, c_credit);
      if (d_credit) begin
        d_cred++;
        d_cred_total++;
      end
      // done exactly one cycle after the last d grant, busy falling with it
      if (done_due) begin
        assert (done && !busy)
          else stop_on_error("done_o missing or busy_o high after the last d grant");
        done_cnt++;
        done_due = 1'b0;
      end else begin
        assert (!done) else stop_on_error("done_o pulsed outside the end of a job");
      end
      if (mem_req && mem_gnt && !mem_wen) begin
        if (d_writes == 0) begin
          assert (d_cred_total == `MAC_FIFO_DEPTH)
            else report_mismatch("d_credit_o pulses", d_cred_total, `MAC_FIFO_DEPTH);
        end
        d_writes++;
        d_grants++;
        if (d_grants == job_n_out) begin
          done_due = 1'b1;
          d_grants = 0;
        end
      end
      compute_result();
    end
  end

  // --------------------
  // job sequence
  // --------------------

  task automatic compare_beats(input string name, input word_t got [$], input word_t exp [$]);
    int i;
    assert (got.size() == exp.size())
      else report_mismatch({name, " beat count"}, got.size(), exp.size());
    for (i = 0; i < exp.size(); i++) begin
      assert (got[i] == exp[i]) else report_mismatch(name, got[i], exp[i]);
    end
  endtask

  task automatic check_job();
    int i;
    assert (i_mem.log_add.size() == exp_add.size())
      else report_mismatch("mem_req_o count", i_mem.log_add.size(), exp_add.size());
    for (i = 0; i < exp_add.size(); i++) begin
      assert (i_mem.log_add[i] == exp_add[i])
        else report_mismatch("mem_add_o", i_mem.log_add[i], exp_add[i]);
      assert (i_mem.log_rd[i] == exp_rd[i])
        else report_mismatch("mem_wen_o", i_mem.log_rd[i], exp_rd[i]);
    end
    compare_beats("a_data_o", got_a, exp_a);
    compare_beats("b_data_o", got_b, exp_b);
    compare_beats("c_data_o", got_c, exp_c);
    for (i = 0; i < exp_d.size(); i++) begin
      assert (mem_word(d_base + addr_t'(`MAC_WORD_BYTES * i)) == exp_d[i])
        else report_mismatch("mem_data_o",
                             mem_word(d_base + addr_t'(`MAC_WORD_BYTES * i)), exp_d[i]);
    end
  endtask

  task automatic run_job(input bit simple, input int np, input int no,
                         input addr_t ab, input addr_t bb, input addr_t cb,
                         input addr_t db, input int pct);
    int cyc;
    int done_before;
    @(posedge clk);
    job_simple  = simple;
    job_pairs   = simple ? 1 : np;
    job_n_out   = no;
    credit_pct  = pct;
    done_before = done_cnt;
    i_mem.log_add.delete();
    i_mem.log_rd.delete();
    got_a.delete();
    got_b.delete();
    got_c.delete();
    #1;
    a_base     = ab;
    b_base     = bb;
    c_base     = cb;
    d_base     = db;
    simple_mul = simple;
    pairs      = cnt_t'(np);
    n_out      = cnt_t'(no);
    start      = 1'b1;
    build_reference(simple, np, no);
    @(posedge clk);
    #1;
    start = 1'b0;
    cyc   = 0;
    while (done_cnt == done_before && cyc < TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    assert (done_cnt != done_before) else stop_on_error("job did not finish before the timeout");
    check_job();
  endtask

  initial begin
    rst_n      = 1'b0;
    start      = 1'b0;
    simple_mul = 1'b0;
    pairs      = '0;
    n_out      = '0;
    a_base     = '0;
    b_base     = '0;
    c_base     = '0;
    d_base     = '0;
    a_credit   = 1'b0;
    b_credit   = 1'b0;
    c_credit   = 1'b0;
    d_valid    = 1'b0;
    d_data     = '0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    assert (!busy && !done && !mem_req && !a_valid && !b_valid && !c_valid)
      else stop_on_error("streamer outputs not idle after reset");
    // MAC, simple multiply with pairs ignored, then MAC with scarce credits
    run_job(1'b0, 3, 5, 32'h000, 32'h100, 32'h200, 32'h300, 60);
    run_job(1'b1, 3, 8, 32'h040, 32'h140, 32'h240, 32'h340, 60);
    run_job(1'b0, 2, 6, 32'h080, 32'h180, 32'h280, 32'h380, 15);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_mac_mem_model.sv
/*
 * word memory model for the streamer testbench
 * grants at random, returns read data one cycle after the grant
 * and logs every accepted request in order
 */

`default_nettype none

module tb_mac_mem_model
  import mac_mem_pkg::*;
#(
  parameter int WORDS   = 256,
  parameter int GNT_PCT = 60
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  addr_t add_i,
  input  logic  wen_i,
  input  word_t data_i,
  output logic  gnt_o,
  output logic  r_valid_o,
  output word_t r_data_o
);

  timeunit 1ns;
  timeprecision 100ps;

  word_t mem [WORDS];
  // accepted requests, wen as seen on the port (1 = read)
  addr_t log_add [$];
  logic  log_rd [$];

  // handshake of the current cycle
  logic  take;
  logic  take_rd;
  int    take_idx;
  word_t take_data;

  initial begin
    int i;
    void'($urandom(39113));
    // every word differs, pattern spans the whole index
    for (i = 0; i < WORDS; i++) begin
      mem[i] = word_t'(i) * 32'h9e37_79b9 + 32'h0f0f_1234;
    end
    take      = 1'b0;
    take_rd   = 1'b0;
    take_idx  = 0;
    take_data = '0;
    gnt_o     = 1'b0;
    r_valid_o = 1'b0;
    r_data_o  = '0;
  end

  // port sampled mid-cycle, where it is stable
  always @(negedge clk_i) begin
    take = rst_ni && req_i && gnt_o;
    if (take) begin
      take_rd   = wen_i;
      take_idx  = int'((add_i >> 2) % WORDS);
      take_data = data_i;
      log_add.push_back(add_i);
      log_rd.push_back(wen_i);
    end
  end

  // read data in the cycle after the grant, writes without response
  always @(posedge clk_i) begin
    #1;
    r_valid_o = take && take_rd;
    r_data_o  = (take && take_rd) ? mem[take_idx] : '0;
    if (take && !take_rd) begin
      mem[take_idx] = take_data;
    end
    take  = 1'b0;
    // back-pressure, independent of req
    gnt_o = ($urandom_range(99) < GNT_PCT);
  end

endmodule

`default_nettype wire

//--- mac_streamer_top.sv
/*
 * memory streamer for the MAC engine, top level
 * three load streams and one store stream share one word-wide port
 */

`default_nettype none

`include "mac_streamer_params.svh"

module mac_streamer_top
  import mac_mem_pkg::*;
  import mac_ctrl_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // job control
  input  logic  start_i,
  input  logic  simple_mul_i,
  input  cnt_t  pairs_i,
  input  cnt_t  n_out_i,
  input  addr_t a_base_i,
  input  addr_t b_base_i,
  input  addr_t c_base_i,
  input  addr_t d_base_i,
  output logic  busy_o,
  output logic  done_o,
  // memory port
  output logic  mem_req_o,
  output addr_t mem_add_o,
  output logic  mem_wen_o,
  output word_t mem_data_o,
  input  logic  mem_gnt_i,
  input  logic  mem_r_valid_i,
  input  word_t mem_r_data_i,
  // engine streams
  output logic  a_valid_o,
  output word_t a_data_o,
  input  logic  a_credit_i,
  output logic  b_valid_o,
  output word_t b_data_o,
  input  logic  b_credit_i,
  output logic  c_valid_o,
  output word_t c_data_o,
  input  logic  c_credit_i,
  input  logic  d_valid_i,
  input  word_t d_data_i,
  output logic  d_credit_o
);

  stream_sel_e sel, resp_sel;
  logic        sel_valid, job_start, mem_hs;

  mac_tcdm_if a_tcdm ();
  mac_tcdm_if b_tcdm ();
  mac_tcdm_if c_tcdm ();
  mac_tcdm_if d_tcdm ();

  // channels restart only on a start the controller accepts
  assign job_start = start_i & ~busy_o;
  // a grant counts only against a live request
  assign mem_hs    = mem_req_o & mem_gnt_i;

  mac_stream_ctrl i_ctrl (
    .clk_i, .rst_ni, .start_i, .simple_mul_i, .pairs_i, .n_out_i,
    .mem_gnt_i   ( mem_hs    ),
    .sel_o       ( sel       ),
    .sel_valid_o ( sel_valid ),
    .resp_sel_o  ( resp_sel  ),
    .busy_o, .done_o
  );

  mac_tcdm_mux i_mux (
    .sel_i ( sel ), .sel_valid_i ( sel_valid ), .resp_sel_i ( resp_sel ),
    .mem_req_o, .mem_add_o, .mem_wen_o, .mem_data_o,
    .mem_gnt_i, .mem_r_valid_i, .mem_r_data_i,
    .a_tcdm, .b_tcdm, .c_tcdm, .d_tcdm
  );

  // --------------------
  // stream channels
  // --------------------

  mac_load_channel #(.DEPTH(`MAC_FIFO_DEPTH), .CREDITS(`MAC_CONSUMER_CREDITS)) i_a_load (
    .clk_i, .rst_ni, .start_i ( job_start ), .base_i ( a_base_i ), .tcdm ( a_tcdm ),
    .valid_o ( a_valid_o ), .data_o ( a_data_o ), .credit_i ( a_credit_i )
  );

  mac_load_channel #(.DEPTH(`MAC_FIFO_DEPTH), .CREDITS(`MAC_CONSUMER_CREDITS)) i_b_load (
    .clk_i, .rst_ni, .start_i ( job_start ), .base_i ( b_base_i ), .tcdm ( b_tcdm ),
    .valid_o ( b_valid_o ), .data_o ( b_data_o ), .credit_i ( b_credit_i )
  );

  mac_load_channel #(.DEPTH(`MAC_FIFO_DEPTH), .CREDITS(`MAC_CONSUMER_CREDITS)) i_c_load (
    .clk_i, .rst_ni, .start_i ( job_start ), .base_i ( c_base_i ), .tcdm ( c_tcdm ),
    .valid_o ( c_valid_o ), .data_o ( c_data_o ), .credit_i ( c_credit_i )
  );

  // result write-back
  mac_store_channel #(.DEPTH(`MAC_FIFO_DEPTH)) i_d_store (
    .clk_i, .rst_ni, .start_i ( job_start ), .base_i ( d_base_i ), .tcdm ( d_tcdm ),
    .valid_i ( d_valid_i ), .data_i ( d_data_i ), .credit_o ( d_credit_o )
  );

endmodule

`default_nettype wire

//--- mac_store_channel.sv
/*
 * store stream: buffers engine results under granted credits and
 * writes them out at linear addresses from the d base
 */

`default_nettype none

`include "mac_streamer_params.svh"

module mac_store_channel
  import mac_mem_pkg::*;
#(
  parameter int unsigned DEPTH = `MAC_FIFO_DEPTH
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  addr_t      base_i,
  mac_tcdm_if.channel tcdm,
  input  logic       valid_i,
  input  word_t      data_i,
  output logic       credit_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  word_t            buf_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] fill_q;
  logic [CNT_W-1:0] pend_q;    // credits not yet handed out
  logic             credit_q;
  addr_t            addr_q;
  logic             issue, grant;

  assign issue = tcdm.req & tcdm.gnt;
  // at most one credit pulse per cycle
  assign grant = (pend_q != '0);

  // --------------------
  // write issue
  // --------------------

  assign tcdm.req  = (fill_q != '0);
  assign tcdm.add  = addr_q;
  assign tcdm.wen  = 1'b0;
  assign tcdm.data = buf_q[rd_ptr_q];
  assign credit_o  = credit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      // a full buffer's worth of credits right after reset
      pend_q   <= CNT_W'(DEPTH);
      credit_q <= 1'b0;
    end else begin
      if (start_i) begin
        addr_q <= base_i;
      end else if (issue) begin
        addr_q <= addr_q + addr_t'(`MAC_WORD_BYTES);
      end
      if (valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (issue) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q   <= fill_q + CNT_W'(valid_i) - CNT_W'(issue);
      // each word written frees one slot, hence one more credit
      pend_q   <= pend_q - CNT_W'(grant) + CNT_W'(issue);
      credit_q <= grant;
    end
  end

  // buffer storage
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      buf_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- mac_load_channel.sv
/*
 * one load stream: linear read addresses, a small buffer for returned
 * words and a credit-based output towards the engine
 * used for the a, b and c streams
 */

`default_nettype none

`include "mac_streamer_params.svh"

module mac_load_channel
  import mac_mem_pkg::*;
#(
  parameter int unsigned DEPTH   = `MAC_FIFO_DEPTH,
  parameter int unsigned CREDITS = `MAC_CONSUMER_CREDITS
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  addr_t      base_i,
  mac_tcdm_if.channel tcdm,
  output logic       valid_o,
  output word_t      data_o,
  input  logic       credit_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam int unsigned CRD_W = $clog2(CREDITS + 1);

  word_t            buf_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] fill_q;    // words held in the buffer
  logic [CNT_W-1:0] occ_q;     // buffered plus reads in flight
  logic [CRD_W-1:0] credit_q;
  addr_t            addr_q;
  logic             issue, push, pop;

  assign issue = tcdm.req & tcdm.gnt;
  assign push  = tcdm.r_valid;
  assign pop   = valid_o;

  // --------------------
  // read issue
  // --------------------

  // stop asking once every slot is spoken for
  assign tcdm.req  = (occ_q < CNT_W'(DEPTH));
  assign tcdm.add  = addr_q;
  assign tcdm.wen  = 1'b1;
  assign tcdm.data = '0;

  // one beat per cycle while a word and a credit are there
  assign valid_o = (fill_q != '0) && (credit_q != '0);
  assign data_o  = buf_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      occ_q    <= '0;
      credit_q <= CRD_W'(CREDITS);
    end else begin
      // base-plus-word-step address
      if (start_i) begin
        addr_q <= base_i;
      end else if (issue) begin
        addr_q <= addr_q + addr_t'(`MAC_WORD_BYTES);
      end
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q   <= fill_q + CNT_W'(push) - CNT_W'(pop);
      occ_q    <= occ_q + CNT_W'(issue) - CNT_W'(pop);
      // spend one per beat, regain one per returned credit
      credit_q <= credit_q - CRD_W'(pop) + CRD_W'(credit_i);
    end
  end

  // buffer storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= tcdm.r_data;
    end
  end

endmodule

`default_nettype wire

//--- mac_tcdm_mux.sv
/*
 * combinational request/response mux onto the single memory port
 * request and grant follow the request select, read data the response select
 */

`default_nettype none

module mac_tcdm_mux
  import mac_mem_pkg::*;
  import mac_ctrl_pkg::*;
(
  input  stream_sel_e    sel_i,
  input  logic           sel_valid_i,
  input  stream_sel_e    resp_sel_i,
  output logic           mem_req_o,
  output addr_t          mem_add_o,
  output logic           mem_wen_o,
  output word_t          mem_data_o,
  input  logic           mem_gnt_i,
  input  logic           mem_r_valid_i,
  input  word_t          mem_r_data_i,
  mac_tcdm_if.mux        a_tcdm,
  mac_tcdm_if.mux        b_tcdm,
  mac_tcdm_if.mux        c_tcdm,
  mac_tcdm_if.mux        d_tcdm
);

  // --------------------
  // request path
  // --------------------

  always_comb begin
    mem_req_o  = 1'b0;
    mem_add_o  = '0;
    mem_wen_o  = 1'b1;
    mem_data_o = '0;
    a_tcdm.gnt = 1'b0;
    b_tcdm.gnt = 1'b0;
    c_tcdm.gnt = 1'b0;
    d_tcdm.gnt = 1'b0;
    // port idle between jobs
    if (sel_valid_i) begin
      unique case (sel_i)
        sel_a: begin
          mem_req_o  = a_tcdm.req;
          mem_add_o  = a_tcdm.add;
          mem_wen_o  = a_tcdm.wen;
          mem_data_o = a_tcdm.data;
          a_tcdm.gnt = mem_gnt_i;
        end
        sel_b: begin
          mem_req_o  = b_tcdm.req;
          mem_add_o  = b_tcdm.add;
          mem_wen_o  = b_tcdm.wen;
          mem_data_o = b_tcdm.data;
          b_tcdm.gnt = mem_gnt_i;
        end
        sel_c: begin
          mem_req_o  = c_tcdm.req;
          mem_add_o  = c_tcdm.add;
          mem_wen_o  = c_tcdm.wen;
          mem_data_o = c_tcdm.data;
          c_tcdm.gnt = mem_gnt_i;
        end
        default: begin
          mem_req_o  = d_tcdm.req;
          mem_add_o  = d_tcdm.add;
          mem_wen_o  = d_tcdm.wen;
          mem_data_o = d_tcdm.data;
          d_tcdm.gnt = mem_gnt_i;
        end
      endcase
    end
  end

  // --------------------
  // response path
  // --------------------

  // only the stream granted last cycle sees r_valid
  assign a_tcdm.r_valid = (resp_sel_i == sel_a) & mem_r_valid_i;
  assign b_tcdm.r_valid = (resp_sel_i == sel_b) & mem_r_valid_i;
  assign c_tcdm.r_valid = (resp_sel_i == sel_c) & mem_r_valid_i;
  assign d_tcdm.r_valid = (resp_sel_i == sel_d) & mem_r_valid_i;
  assign a_tcdm.r_data  = (resp_sel_i == sel_a) ? mem_r_data_i : '0;
  assign b_tcdm.r_data  = (resp_sel_i == sel_b) ? mem_r_data_i : '0;
  assign c_tcdm.r_data  = (resp_sel_i == sel_c) ? mem_r_data_i : '0;
  assign d_tcdm.r_data  = (resp_sel_i == sel_d) ? mem_r_data_i : '0;

endmodule

`default_nettype wire

//--- mac_stream_ctrl.sv
/*
 * job sequencer of the streamer
 * steps the request select on each grant and delays it by one cycle
 * for the read response, counts pairs and results, flags busy and done
 */

`default_nettype none

module mac_stream_ctrl
  import mac_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        start_i,
  input  logic        simple_mul_i,
  input  cnt_t        pairs_i,
  input  cnt_t        n_out_i,
  input  logic        mem_gnt_i,
  output stream_sel_e sel_o,
  output logic        sel_valid_o,
  output stream_sel_e resp_sel_o,
  output logic        busy_o,
  output logic        done_o
);

  job_cfg_t    cfg_q;
  stream_sel_e sel_q, sel_n, resp_sel_q;
  cnt_t        pair_cnt_q, out_cnt_q;
  logic        busy_q, done_q;
  logic        start, step, last_pair, last_out;

  // a new job only from idle
  assign start     = start_i & ~busy_q;
  assign step      = busy_q & mem_gnt_i;
  assign last_pair = (pair_cnt_q == cfg_q.pairs - 1'b1);
  assign last_out  = (out_cnt_q == cfg_q.n_out - 1'b1);

  // --------------------
  // request select
  // --------------------

  always_comb begin
    sel_n = sel_q;
    if (step) begin
      unique case (sel_q)
        sel_a: sel_n = sel_b;
        sel_b: begin
          // simple mode skips c, MAC loops on a/b until the last pair
          if (cfg_q.simple_mul) begin
            sel_n = sel_d;
          end else if (last_pair) begin
            sel_n = sel_c;
          end else begin
            sel_n = sel_a;
          end
        end
        sel_c: sel_n = sel_d;
        sel_d: sel_n = sel_a;
        default: sel_n = sel_a;
      endcase
    end
  end

  // --------------------
  // job state
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q      <= '0;
      sel_q      <= sel_a;
      resp_sel_q <= sel_a;
      pair_cnt_q <= '0;
      out_cnt_q  <= '0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q     <= 1'b0;
      // read data comes back exactly one cycle after its grant
      resp_sel_q <= sel_q;
      sel_q      <= sel_n;
      if (start) begin
        cfg_q      <= '{simple_mul: simple_mul_i, pairs: pairs_i, n_out: n_out_i};
        sel_q      <= sel_a;
        pair_cnt_q <= '0;
        out_cnt_q  <= '0;
        busy_q     <= 1'b1;
      end else if (step) begin
        // b grants count pairs in MAC mode
        if (sel_q == sel_b && !cfg_q.simple_mul) begin
          pair_cnt_q <= last_pair ? '0 : pair_cnt_q + 1'b1;
        end
        // d grants count results, the last one ends the job
        if (sel_q == sel_d) begin
          if (last_out) begin
            out_cnt_q <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b1;
          end else begin
            out_cnt_q <= out_cnt_q + 1'b1;
          end
        end
      end
    end
  end

  assign sel_o       = sel_q;
  assign sel_valid_o = busy_q;
  assign resp_sel_o  = resp_sel_q;
  assign busy_o      = busy_q;
  assign done_o      = done_q;

endmodule

`default_nettype wire

//--- mac_tcdm_if.sv
/*
 * one stream's view of the shared memory port (TCDM style)
 * channels use the channel modport, the request mux the mux modport
 */

`default_nettype none

interface mac_tcdm_if
  import mac_mem_pkg::*;
();

  // request side, driven by the stream channel
  logic  req;
  addr_t add;
  logic  wen;     // 1 = read, 0 = write
  word_t data;

  // response side, driven by the mux
  logic  gnt;
  logic  r_valid;
  word_t r_data;

  modport channel (
    output req, add, wen, data,
    input  gnt, r_valid, r_data
  );

  modport mux (
    input  req, add, wen, data,
    output gnt, r_valid, r_data
  );

endinterface

`default_nettype wire

//--- mac_ctrl_pkg.sv
/*
 * control-side types of the streamer
 * stream select, job counts and the job setting held during a run
 */

`default_nettype none

`include "mac_streamer_params.svh"

package mac_ctrl_pkg;

  // owner of the memory port
  typedef enum logic [1:0] {
    sel_a = 2'd0,
    sel_b = 2'd1,
    sel_c = 2'd2,
    sel_d = 2'd3
  } stream_sel_e;

  // pair and output counts
  typedef logic [`MAC_CNT_WIDTH-1:0] cnt_t;

  // latched at start, stable for the whole job
  typedef struct packed {
    logic simple_mul;  // a, b, d per result
    cnt_t pairs;       // a/b pairs per result in MAC mode
    cnt_t n_out;       // results in the job
  } job_cfg_t;

endpackage

`default_nettype wire

//--- mac_mem_pkg.sv
/*
 * memory-side types of the streamer
 * shared by the port interface, the mux and the stream channels
 */

`default_nettype none

`include "mac_streamer_params.svh"

package mac_mem_pkg;

  // --------------------
  // memory port payload
  // --------------------

  // one full data word, every access is word wide
  typedef logic [`MAC_DATA_WIDTH-1:0] word_t;

  // byte address
  // streams step it by MAC_WORD_BYTES
  typedef logic [`MAC_ADDR_WIDTH-1:0] addr_t;

endpackage

`default_nettype wire

//--- mac_streamer_params.svh
/*
 * global sizing of the MAC memory streamer
 * include wherever a width, a buffer depth or a credit count is needed
 */

`ifndef MAC_STREAMER_PARAMS_SVH
`define MAC_STREAMER_PARAMS_SVH

// memory word and byte address
`define MAC_DATA_WIDTH 32
`define MAC_ADDR_WIDTH 32

// address step per beat, one full word
`define MAC_WORD_BYTES 4

// entries per channel buffer
`define MAC_FIFO_DEPTH 4

// engine-side buffer depth, i.e. initial credits of a load stream
`define MAC_CONSUMER_CREDITS 2

// width of the pairs and output counts
`define MAC_CNT_WIDTH 16

`endif
